//--- Makefile
# Verilator build and run for the L1 instruction cache testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_icache_l1
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := All checks passed
SIMFLAGS  := +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, not the simulator exit code
run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/cache_cfg_pkg.sv
// cache geometry constants, width typedefs and address field helpers
package cache_cfg_pkg;

  // address geometry
  localparam int ADDR_LEN = 32;              // physical byte address
  localparam int IDX_LEN  = 6;               // set index
  localparam int OFFS_LEN = 4;               // byte offset within a line
  localparam int TAG_LEN  = ADDR_LEN - IDX_LEN - OFFS_LEN; // 22

  // line geometry
  localparam int WORD_LEN       = 32;        // one instruction
  localparam int LINE_LEN       = 128;
  localparam int WORDS_PER_LINE = LINE_LEN / WORD_LEN; // 4

  localparam int NUM_SETS = 1 << IDX_LEN;    // 64 sets
  localparam int WSEL_LEN = $clog2(WORDS_PER_LINE); // word select inside a line

  typedef logic [ADDR_LEN-1:0] addr_t;
  typedef logic [TAG_LEN-1:0]  tag_t;
  typedef logic [IDX_LEN-1:0]  idx_t;
  typedef logic [OFFS_LEN-1:0] offs_t;
  typedef logic [WSEL_LEN-1:0] wsel_t;
  typedef logic [WORD_LEN-1:0] word_t;
  typedef logic [LINE_LEN-1:0] line_t;

  // address slicing, kept here so every block splits the same way
  function automatic tag_t addr_tag(addr_t a);
    return a[ADDR_LEN-1 -: TAG_LEN];
  endfunction

  function automatic idx_t addr_idx(addr_t a);
    return a[OFFS_LEN +: IDX_LEN];
  endfunction

  function automatic offs_t addr_offs(addr_t a);
    return a[OFFS_LEN-1:0];
  endfunction

endpackage

//--- design/cache_if_pkg.sv
// channel structs for front-end, L2 and way control, controller state enum
package cache_if_pkg;
  import cache_cfg_pkg::*;

  // front-end fetch request
  typedef struct packed {
    logic  valid;
    addr_t addr;   // physical, no translation
  } fe_req_t;

  // fetch answer, single-cycle strobe
  typedef struct packed {
    logic  valid;
    addr_t addr;   // echo of the accepted address
    word_t word;
  } fe_resp_t;

  // line request towards the L2 arbiter
  typedef struct packed {
    logic  valid;
    addr_t addr;   // line aligned
  } l2_req_t;

  // line answer from L2, strobe
  typedef struct packed {
    logic  valid;
    line_t line;
  } l2_resp_t;

  // per-way RAM control, one copy for each way
  typedef struct packed {
    logic cs;      // tag and data RAM select
    logic we;      // refill write
    idx_t idx;     // set being read or written
    tag_t tag;     // lookup tag or refill tag
  } way_ctrl_t;

  // controller FSM
  typedef enum logic [2:0] {
    IDLE,          // waiting, ready high
    LOOKUP,        // RAM data out, compare tags
    MISS_REQ,      // l2 request pending
    MISS_WAIT,     // waiting for the line
    REFILL,        // line written, answer
    FLUSH          // clearing all valid bits
  } ctrl_state_e;

endpackage

//--- design/icache_ctrl.sv
// cache controller: lookup and refill FSM, round-robin victim, L2 request channel
`timescale 1ns/1ps

module icache_ctrl
  import cache_cfg_pkg::*;
  import cache_if_pkg::*;
#(
  parameter int NUM_WAYS = 4
) (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     flush_i,
  // front-end
  input  fe_req_t                  fe_req_i,
  output logic                     ready_o,
  output fe_resp_t                 fe_resp_o,
  // L2 arbiter
  output l2_req_t                  l2_req_o,
  input  logic                     l2_ready_i,
  input  l2_resp_t                 l2_resp_i,
  // ways
  output way_ctrl_t [NUM_WAYS-1:0] way_ctrl_o,
  output logic                     way_flush_o,
  // hit selector
  input  logic                     miss_i,
  input  word_t                    word_i,
  output offs_t                    offs_o
);

  localparam int VICT_LEN = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;
  typedef logic [VICT_LEN-1:0] vict_t;

  ctrl_state_e state_q, state_d;
  addr_t       addr_q;           // accepted fetch address
  vict_t       victim_q;         // next way to replace
  logic        resp_valid_q;
  logic        resp_valid_d;
  word_t       resp_word_q;
  word_t       resp_word_d;
  logic        resp_word_en;
  logic        accept;
  logic        refill_we;        // line arrives this cycle
  wsel_t       wsel;
  word_t       refill_word;

  assign ready_o   = (state_q == IDLE) & ~flush_i; // flush wins over a fetch
  assign accept    = fe_req_i.valid & ready_o;
  assign refill_we = (state_q == MISS_WAIT) & l2_resp_i.valid;

  assign offs_o      = addr_offs(addr_q);
  assign wsel        = addr_q[OFFS_LEN-1 -: WSEL_LEN];
  assign refill_word = l2_resp_i.line[wsel*WORD_LEN +: WORD_LEN]; // fetched word from fresh line

  // way control
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      way_ctrl_o[w].cs  = 1'b0;
      way_ctrl_o[w].we  = 1'b0;
      way_ctrl_o[w].idx = addr_idx(addr_q);
      way_ctrl_o[w].tag = addr_tag(addr_q);
      if (accept) begin
        // read every way straight from the incoming address
        way_ctrl_o[w].cs  = 1'b1;
        way_ctrl_o[w].idx = addr_idx(fe_req_i.addr);
        way_ctrl_o[w].tag = addr_tag(fe_req_i.addr);
      end else if (refill_we && (victim_q == vict_t'(w))) begin
        way_ctrl_o[w].cs = 1'b1; // write only the victim
        way_ctrl_o[w].we = 1'b1;
      end
    end
  end

  // next state
  always_comb begin
    state_d      = state_q;
    resp_valid_d = 1'b0;
    resp_word_en = 1'b0;
    resp_word_d  = word_i;
    way_flush_o  = 1'b0;
    case (state_q)
      IDLE: begin
        if (flush_i) begin
          state_d = FLUSH;
        end else if (accept) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        if (miss_i) begin
          state_d = MISS_REQ;
        end else begin
          state_d      = IDLE; // hit, answer now
          resp_valid_d = 1'b1;
          resp_word_en = 1'b1;
        end
      end
      MISS_REQ: begin
        if (l2_ready_i) begin
          state_d = MISS_WAIT; // request taken by L2
        end
      end
      MISS_WAIT: begin
        if (l2_resp_i.valid) begin
          state_d      = REFILL; // write lands on this edge
          resp_word_en = 1'b1;
          resp_word_d  = refill_word;
        end
      end
      REFILL: begin
        state_d      = IDLE;
        resp_valid_d = 1'b1;
      end
      FLUSH: begin
        state_d     = IDLE;
        way_flush_o = 1'b1; // valid bits drop on the next edge
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= IDLE;
      resp_valid_q <= 1'b0;
      victim_q     <= '0;
    end else begin
      state_q      <= state_d;
      resp_valid_q <= resp_valid_d;
      if (state_q == REFILL) begin
        // round robin, wraps at the last way
        victim_q <= (victim_q == vict_t'(NUM_WAYS-1)) ? '0 : victim_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= fe_req_i.addr;
    end
    if (resp_word_en) begin
      resp_word_q <= resp_word_d;
    end
  end

  // outputs, addr_q stays put while a miss is pending
  assign l2_req_o  = '{valid: (state_q == MISS_REQ),
                       addr:  {addr_q[ADDR_LEN-1:OFFS_LEN], {OFFS_LEN{1'b0}}}};
  assign fe_resp_o = '{valid: resp_valid_q, addr: addr_q, word: resp_word_q};

endmodule

//--- design/icache_hit_sel.sv
// hit selector: one-hot way select, word extract by offset, miss flag
`timescale 1ns/1ps

module icache_hit_sel
  import cache_cfg_pkg::*;
#(
  parameter int NUM_WAYS = 4
) (
  input  logic  [NUM_WAYS-1:0] hit_vec_i,  // at most one bit set
  input  line_t [NUM_WAYS-1:0] line_vec_i,
  input  offs_t                offs_i,     // byte offset of the fetch
  output logic                 miss_o,
  output word_t                word_o
);

  line_t sel_line;
  wsel_t wsel;

  // and-or mux, a single hitting way passes through
  always_comb begin
    sel_line = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (hit_vec_i[w]) begin
        sel_line = sel_line | line_vec_i[w];
      end
    end
  end

  assign wsel   = offs_i[OFFS_LEN-1 -: WSEL_LEN]; // drop byte bits
  assign word_o = sel_line[wsel*WORD_LEN +: WORD_LEN];
  assign miss_o = ~|hit_vec_i; // no way hit

endmodule

//--- design/icache_l1_top.sv
// L1 instruction cache top: controller, generated ways and hit selector
`timescale 1ns/1ps

module icache_l1_top
  import cache_cfg_pkg::*;
  import cache_if_pkg::*;
#(
  parameter int NUM_WAYS = 4
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     flush_i,    // invalidate all lines
  // front-end
  input  fe_req_t  fe_req_i,
  output logic     ready_o,
  output fe_resp_t fe_resp_o,
  // L2 arbiter
  output l2_req_t  l2_req_o,
  input  logic     l2_ready_i,
  input  l2_resp_t l2_resp_i
);

  way_ctrl_t [NUM_WAYS-1:0] way_ctrl;
  logic      [NUM_WAYS-1:0] hit_vec;
  line_t     [NUM_WAYS-1:0] line_vec;
  logic                     way_flush;
  logic                     miss;
  word_t                    word;
  offs_t                    offs;

  icache_ctrl #(
    .NUM_WAYS(NUM_WAYS)
  ) i_ctrl (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .flush_i    (flush_i),
    .fe_req_i   (fe_req_i),
    .ready_o    (ready_o),
    .fe_resp_o  (fe_resp_o),
    .l2_req_o   (l2_req_o),
    .l2_ready_i (l2_ready_i),
    .l2_resp_i  (l2_resp_i),
    .way_ctrl_o (way_ctrl),
    .way_flush_o(way_flush),
    .miss_i     (miss),
    .word_i     (word),
    .offs_o     (offs)
  );

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
    icache_way i_way (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .flush_i (way_flush),
      .ctrl_i  (way_ctrl[w]),
      .line_i  (l2_resp_i.line), // refill straight from L2
      .hit_o   (hit_vec[w]),
      .line_o  (line_vec[w])
    );
  end

  icache_hit_sel #(
    .NUM_WAYS(NUM_WAYS)
  ) i_hit_sel (
    .hit_vec_i (hit_vec),
    .line_vec_i(line_vec),
    .offs_i    (offs),
    .miss_o    (miss),
    .word_o    (word)
  );

endmodule

//--- design/icache_way.sv
// one cache way: valid flops, tag RAM, data RAM and tag compare
`timescale 1ns/1ps

module icache_way
  import cache_cfg_pkg::*;
  import cache_if_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      flush_i,   // clear every valid bit
  input  way_ctrl_t ctrl_i,    // from the controller
  input  line_t     line_i,    // refill data from L2
  output logic      hit_o,     // meaningful in the cycle after a read
  output line_t     line_o
);

  logic [NUM_SETS-1:0] valid_q; // flops, so flush takes one cycle
  idx_t                idx_q;   // set of the pending lookup
  tag_t                tag_q;   // tag of the pending lookup
  tag_t                tag_rd;  // stored tag out of the RAM
  logic                rd_en;

  assign rd_en = ctrl_i.cs & ~ctrl_i.we;

  // valid bits
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (ctrl_i.cs && ctrl_i.we) begin
      valid_q[ctrl_i.idx] <= 1'b1; // line filled
    end
  end

  // lookup key follows the RAM read by one cycle
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      idx_q <= ctrl_i.idx;
      tag_q <= ctrl_i.tag;
    end
  end

  ssram #(
    .NUM_WORDS(NUM_SETS),
    .DATA_LEN (TAG_LEN)
  ) i_tag_ram (
    .clk_i  (clk_i),
    .cs_i   (ctrl_i.cs),
    .we_i   (ctrl_i.we),
    .addr_i (ctrl_i.idx),
    .wdata_i(ctrl_i.tag),
    .rdata_o(tag_rd)
  );

  ssram #(
    .NUM_WORDS(NUM_SETS),
    .DATA_LEN (LINE_LEN)
  ) i_data_ram (
    .clk_i  (clk_i),
    .cs_i   (ctrl_i.cs),
    .we_i   (ctrl_i.we),
    .addr_i (ctrl_i.idx),
    .wdata_i(line_i),
    .rdata_o(line_o)
  );

  assign hit_o = valid_q[idx_q] & (tag_rd == tag_q); // valid and same tag

endmodule

//--- design/ssram.sv
// single-port synchronous RAM with chip select and write enable
`timescale 1ns/1ps

module ssram #(
  parameter int NUM_WORDS = 64,
  parameter int DATA_LEN  = 32
) (
  input  logic                         clk_i,
  input  logic                         cs_i,    // chip select
  input  logic                         we_i,    // write when selected
  input  logic [$clog2(NUM_WORDS)-1:0] addr_i,
  input  logic [DATA_LEN-1:0]          wdata_i,
  output logic [DATA_LEN-1:0]          rdata_o  // valid one edge after a read
);

  logic [DATA_LEN-1:0] mem [NUM_WORDS];
  logic [DATA_LEN-1:0] rdata_q;

  always_ff @(posedge clk_i) begin
    if (cs_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i; // rdata_q keeps last read
      end else begin
        rdata_q <= mem[addr_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- tb/icache_asserts.sv
// concurrent port checks: reset state, hit and miss timing, L2 hold, response strobes
`timescale 1ns/1ps

module icache_asserts
  import cache_if_pkg::*;
(
  input logic     clk_i,
  input logic     arst_n_i,
  input fe_req_t  fe_req_i,
  input logic     ready_i,    // cache ready
  input fe_resp_t fe_resp_i,
  input l2_req_t  l2_req_i,
  input logic     l2_ready_i,
  input l2_resp_t l2_resp_i,
  input logic     miss_i      // hit selector output, valid in LOOKUP
);

  int unsigned fail_cnt = 0;  // assertion failures so far
  logic        accept;

  assign accept = fe_req_i.valid & ready_i; // fetch taken on this edge

  // first edge out of reset: idle and quiet
  reset_idle: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> ready_i && !fe_resp_i.valid && !l2_req_i.valid)
  else begin
    fail_cnt++;
    $error("cache not idle right after reset");
  end

  // hit answers two edges after acceptance, no L2 traffic
  hit_timing: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $past(accept) && !miss_i |=> fe_resp_i.valid && !l2_req_i.valid)
  else begin
    fail_cnt++;
    $error("hit response not two cycles after acceptance");
  end

  // miss goes to L2 on the cycle after LOOKUP
  miss_to_l2: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $past(accept) && miss_i |=> l2_req_i.valid && !fe_resp_i.valid)
  else begin
    fail_cnt++;
    $error("miss did not raise an L2 request");
  end

  // request held until the arbiter takes it
  l2_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    l2_req_i.valid && !l2_ready_i |=> l2_req_i.valid && $stable(l2_req_i.addr))
  else begin
    fail_cnt++;
    $error("L2 request dropped or changed before l2_ready");
  end

  // one-cycle strobe
  resp_strobe: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    fe_resp_i.valid |=> !fe_resp_i.valid)
  else begin
    fail_cnt++;
    $error("fetch response held longer than one cycle");
  end

  // blocking cache, nothing accepted while a line is outstanding
  busy_on_miss: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    l2_req_i.valid || l2_resp_i.valid |-> !ready_i)
  else begin
    fail_cnt++;
    $error("ready raised while a miss was in progress");
  end

endmodule

//--- tb/tb_icache_l1.sv
// testbench for the L1 instruction cache: clock, reset, L2 model, directed and random fetches
`timescale 1ns/1ps

module tb_icache_l1
  import cache_cfg_pkg::*;
  import cache_if_pkg::*;
();

  localparam int RST_CYCLES  = 16;
  localparam int N_DIRECTED  = 15;   // cold miss, hits, eviction, flush
  localparam int N_RANDOM    = 40;
  localparam int WDOG_CYCLES = RST_CYCLES + 200 * (N_DIRECTED + N_RANDOM);

  logic     clk_i;
  logic     arst_n_i;
  logic     flush_i;
  fe_req_t  fe_req_i;
  logic     ready_o;
  fe_resp_t fe_resp_o;
  l2_req_t  l2_req_o;
  logic     l2_ready_i;
  l2_resp_t l2_resp_i;

  int    err_cnt    = 0;
  int    l2_req_cnt = 0;       // accepted L2 requests
  addr_t cur_addr   = '0;      // fetch in flight
  string cur_test   = "none";

  icache_l1_top #(
    .NUM_WAYS(4)
  ) UUT (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .flush_i   (flush_i),
    .fe_req_i  (fe_req_i),
    .ready_o   (ready_o),
    .fe_resp_o (fe_resp_o),
    .l2_req_o  (l2_req_o),
    .l2_ready_i(l2_ready_i),
    .l2_resp_i (l2_resp_i)
  );

  bind icache_l1_top icache_asserts i_asserts (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .fe_req_i  (fe_req_i),
    .ready_i   (ready_o),
    .fe_resp_i (fe_resp_o),
    .l2_req_i  (l2_req_o),
    .l2_ready_i(l2_ready_i),
    .l2_resp_i (l2_resp_i),
    .miss_i    (miss)
  );

  always #5 clk_i = ~clk_i; // 10 ns period

  // memory content: word-aligned address xor a fixed pattern
  function automatic word_t mem_word(input addr_t a);
    return {a[ADDR_LEN-1:2], 2'b00} ^ 32'hA5A5_0000;
  endfunction

  function automatic line_t mem_line(input addr_t line_addr);
    line_t l;
    for (int i = 0; i < WORDS_PER_LINE; i++) begin
      l[i*WORD_LEN +: WORD_LEN] = mem_word(line_addr + addr_t'(4 * i)); // word 0 lowest
    end
    return l;
  endfunction

  // five tags, all in set 5
  function automatic addr_t evict_addr(input int k);
    return 32'h0002_0000 + addr_t'(k) * 32'h400 + 32'h50 + addr_t'(4 * (k % 4));
  endfunction

  // L2 model, random stall on ready, answer after 3 to 8 cycles
  initial begin : l2_model
    addr_t line_addr;
    int    delay;
    forever begin
      @(negedge clk_i);
      if (l2_req_o.valid && l2_ready_i) begin
        line_addr = l2_req_o.addr;
        l2_req_cnt++;
        assert (line_addr == {cur_addr[ADDR_LEN-1:OFFS_LEN], {OFFS_LEN{1'b0}}}) else begin
          err_cnt++;
          $display("ERR %s: expected l2 addr %h actual %h", cur_test,
                   {cur_addr[ADDR_LEN-1:OFFS_LEN], {OFFS_LEN{1'b0}}}, line_addr);
        end
        delay = 3 + int'($urandom % 6);
        @(posedge clk_i);
        #1 l2_ready_i = 1'b0;
        repeat (delay - 1) @(posedge clk_i);
        #1 l2_resp_i = '{valid: 1'b1, line: mem_line(line_addr)};
        @(posedge clk_i);
        #1 l2_resp_i.valid = 1'b0;
      end else begin
        @(posedge clk_i);
        #1 l2_ready_i = (($urandom % 4) != 0); // stall about one cycle in four
      end
    end
  end

  // one fetch, waits for accept and answer, reports whether L2 was used
  task automatic fetch(input addr_t addr, output bit used_l2);
    int l2_before;
    word_t exp_word;
    l2_before = l2_req_cnt;
    exp_word  = mem_word(addr);
    cur_addr  = addr;
    @(posedge clk_i);
    #1 fe_req_i = '{valid: 1'b1, addr: addr};
    @(negedge clk_i);
    while (!ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #1 fe_req_i.valid = 1'b0;
    @(negedge clk_i);
    while (!fe_resp_o.valid) @(negedge clk_i);
    assert (fe_resp_o.word == exp_word) else begin
      err_cnt++;
      $display("ERR %s: expected %h actual %h (addr %h)", cur_test, exp_word,
               fe_resp_o.word, addr);
    end
    assert (fe_resp_o.addr == addr) else begin
      err_cnt++;
      $display("ERR %s: expected resp addr %h actual %h", cur_test, addr, fe_resp_o.addr);
    end
    used_l2 = (l2_req_cnt != l2_before);
  endtask

  task automatic expect_l2(input bit used, input bit exp, input string what);
    assert (used == exp) else begin
      err_cnt++;
      $display("ERR %s: expected l2 request %0b actual %0b (%s, addr %h)", cur_test, exp,
               used, what, cur_addr);
    end
  endtask

  // single-cycle flush pulse from IDLE
  task automatic pulse_flush();
    @(posedge clk_i);
    #1 flush_i = 1'b1;
    @(posedge clk_i);
    #1 flush_i = 1'b0;
  endtask

  initial begin : watchdog
    repeat (WDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, a handshake never completed", WDOG_CYCLES);
    $display("Checks failed");
    $finish;
  end

  initial begin : main
    bit    l2_used;
    addr_t rnd_addr;
    int    total_fail;
    void'($urandom(32'h9731));
    clk_i      = 1'b0;
    arst_n_i   = 1'b1;
    flush_i    = 1'b0;
    fe_req_i   = '0;
    l2_ready_i = 1'b0;
    l2_resp_i  = '0;
    #1 arst_n_i = 1'b0; // clean falling edge for the async reset
    repeat (RST_CYCLES) @(posedge clk_i);
    #1 arst_n_i = 1'b1;
    repeat (2) @(posedge clk_i);

    cur_test = "cold_miss";
    fetch(32'h0000_1008, l2_used);
    expect_l2(l2_used, 1'b1, "first touch");

    cur_test = "hit";                 // same line, other words
    fetch(32'h0000_1000, l2_used);
    expect_l2(l2_used, 1'b0, "cached line");
    fetch(32'h0000_100C, l2_used);
    expect_l2(l2_used, 1'b0, "cached line");

    // four fills, then the fifth lands on the first line's way
    cur_test = "eviction";
    for (int k = 0; k < 5; k++) begin
      fetch(evict_addr(k), l2_used);
      expect_l2(l2_used, 1'b1, "fill");
    end
    for (int k = 1; k < 5; k++) begin
      fetch(evict_addr(k), l2_used);
      expect_l2(l2_used, 1'b0, "still resident");
    end
    fetch(evict_addr(0), l2_used);
    expect_l2(l2_used, 1'b1, "evicted line");

    cur_test = "flush";
    fetch(32'h0000_1008, l2_used);
    expect_l2(l2_used, 1'b0, "before flush");
    pulse_flush();
    fetch(32'h0000_1004, l2_used);
    expect_l2(l2_used, 1'b1, "after flush");

    // 8 KB window, mix of hits and misses
    cur_test = "random";
    for (int n = 0; n < N_RANDOM; n++) begin
      rnd_addr = 32'h0010_0000 + addr_t'($urandom % 32'h2000);
      repeat ($urandom % 3) @(posedge clk_i);
      fetch(rnd_addr, l2_used);
    end

    repeat (4) @(posedge clk_i);
    total_fail = err_cnt + int'(UUT.i_asserts.fail_cnt);
    $display("closing: %0d data check errors, %0d assertion failures", err_cnt,
             UUT.i_asserts.fail_cnt);
    if (total_fail == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
design/cache_cfg_pkg.sv
design/cache_if_pkg.sv
design/ssram.sv
design/icache_way.sv
design/icache_hit_sel.sv
design/icache_ctrl.sv
design/icache_l1_top.sv
tb/icache_asserts.sv
tb/tb_icache_l1.sv
